// ==== Makefile ====
# Verilator build and run of the CPS2 decryptor testbench

.PHONY: sim clean

# Pass only when the log holds the testbench pass line
sim:
	verilator --binary --timing --assert -f flist.f --top-module cps2_tb -Mdir obj_dir
	./obj_dir/Vcps2_tb | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/cps2_properties.sv ====
`timescale 1ns/1ps
// Bus handshake and pipeline latency assertions, bound into the slave and decryptor
module cps2_properties (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic in_valid,
    input logic out_valid
);
    import cps2_pkg::*;

    // Ack answers a request taken on the cycle before
    a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
        ack |-> $past(cyc && stb && !ack))
        else $error("ack without a request in the previous cycle");

    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        ack |=> !ack)
        else $error("ack high for two cycles");

    // Fixed pipeline latency, decrypted or not
    a_out_after_in: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> ##N_ROUNDS out_valid)
        else $error("out_valid missing four cycles after in_valid");

    a_in_before_out: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(in_valid, N_ROUNDS))
        else $error("out_valid without in_valid four cycles earlier");

endmodule

// ==== dv/cps2_tb.sv ====
`timescale 1ns/1ps
// Testbench for the CPS2 decryption front end
// Wishbone driver tasks, key and cipher reference model, directed tests
module cps2_tb;
    import cps2_pkg::*;

    localparam int TIMEOUT = 200;                   // Cycles allowed per wait
    // Source bit of each output word bit, MSB first, relative to the source word
    localparam int SRC_OFF [16] = '{10, 11, 12, 13, 14, 15, 0, 1, 2, 3, 4, 5, 6, 7, -8, -7};

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [15:0] wb_dat_i;
    logic [15:0] wb_dat_o;
    logic        wb_ack;

    integer       seed = 32'h6999_ed52;
    int           errors = 0;
    int           tests = 0;
    int           perm [CFG_W];                     // Config bit p takes raw bit perm[p]
    logic [7:0]   cfg_bytes [CFG_BYTES];
    logic [159:0] m_raw;                            // Model of the loader state
    logic [11:0]  m_sum;
    logic [4:0]   m_count;
    logic         m_beta;
    logic [15:0]  rd_data;                          // Last bus read

    always #2 clk = ~clk;

    cps2_top i_cps2_top (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack)
    );

    bind cps2_wb_regs cps2_properties i_bus_props (
        .clk(clk), .rst(rst), .cyc(wb_cyc), .stb(wb_stb), .ack(wb_ack),
        .in_valid(in_valid), .out_valid(out_valid)
    );
    bind cps2_decrypt cps2_properties i_pipe_props (
        .clk(clk), .rst(rst), .cyc(1'b0), .stb(1'b0), .ack(1'b0),
        .in_valid(in_valid), .out_valid(out_valid)
    );

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [7:0] rol8(input logic [7:0] x, input int n);
        return (x << n) | (x >> (8 - n));
    endfunction

    function automatic logic beta_hit(input logic [11:0] s);
        for (int i = 0; i < BETA_N; i++) begin
            if (BETA_SUMS[i] == s) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [159:0] unscramble(input logic [159:0] raw);
        logic [159:0] cfg;
        for (int p = 0; p < CFG_W; p++) cfg[p] = raw[perm[p]];
        return cfg;
    endfunction

    function automatic logic [63:0] model_key();
        logic [159:0] cfg;
        cfg = unscramble(m_raw);
        return cfg[63:0] | ((BETA_EN && m_beta) ? 64'h3FF : 64'h0);   // Beta override
    endfunction

    function automatic logic [15:0] model_rng();
        logic [159:0] cfg;
        cfg = unscramble(m_raw);
        return cfg[159:144];
    endfunction

    // Feistel rounds, word passes untouched outside the limit
    function automatic logic [15:0] ref_decrypt(input logic [15:0] w, input logic [23:0] a);
        logic [63:0] k;
        logic [7:0]  hi;
        logic [7:0]  lo;
        logic [7:0]  t;
        k  = model_key();
        hi = w[15:8];
        lo = w[7:0];
        if (a[23:8] >= model_rng()) return w;
        for (int r = 0; r < N_ROUNDS; r++) begin
            t  = hi ^ rol8(lo ^ k[8*r +: 8] ^ a[7:0], r + 1);
            hi = lo;
            lo = t;
        end
        return {hi, lo};
    endfunction

    function automatic logic [23:0] addr_below();
        logic [15:0] top;
        top = (model_rng() == 16'h0) ? 16'h0 : 16'(rand32() % {16'h0, model_rng()});
        return {top, 8'(rand32())};
    endfunction

    task automatic build_perm();
        int s;
        for (int w = 0; w < CFG_W / 16; w++) begin
            s = (w < 6) ? w : (w ^ 1);                 // Key words trade places in pairs
            for (int j = 0; j < 16; j++) begin
                perm[CFG_W - 1 - 16 * w - j] = (16 * s + SRC_OFF[j] + CFG_W) % CFG_W;
            end
        end
    endtask

    task automatic finish_run();
        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        errors++;
        $display("Timed out at %0t while waiting for %s", $time, what);
        finish_run();
    endtask

    task automatic wait_ack();
        int n;
        n = 0;
        @(negedge clk);
        while (!wb_ack) begin
            if (n == TIMEOUT) stop_on_timeout("wb_ack");
            n++;
            @(negedge clk);
        end
    endtask

    task automatic wb_access(input logic we, input logic [2:0] adr, input logic [15:0] dat);
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = dat;
        wait_ack();
        rd_data = wb_dat_o;                         // Read data valid with ack
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
        @(negedge clk);
        if (wb_ack) begin
            errors++;
            $display("Ack stayed high for a second cycle at %0t", $time);
        end
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [15:0] dat);
        wb_access(1'b1, adr, dat);
    endtask

    task automatic wb_read(input logic [2:0] adr);
        wb_access(1'b0, adr, 16'h0000);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        wb_read(REG_STATUS);
        while (rd_data[0]) begin                    // Busy bit
            if (n == TIMEOUT) stop_on_timeout("busy to clear");
            n++;
            wb_read(REG_STATUS);
        end
    endtask

    task automatic load_key();
        for (int i = 0; i < CFG_BYTES; i++) begin
            wb_write(REG_KEYDATA, {8'h00, cfg_bytes[i]});
            m_raw   = {cfg_bytes[i], m_raw[159:8]};  // Newest byte enters at the top
            m_sum   = m_sum + {4'h0, cfg_bytes[i]};
            m_count = m_count + 5'd1;
            m_beta  = beta_hit(m_sum);
        end
        repeat (3) @(negedge clk);                  // Beta lags the last byte by two cycles
        wb_read(REG_STATUS);
        if (rd_data !== {8'h00, m_count, 1'b0, m_beta, 1'b0}) begin
            errors++;
            $display("[FAIL] %0t status got %h expected %h", $time, rd_data,
                     {8'h00, m_count, 1'b0, m_beta, 1'b0});
        end
    endtask

    task automatic decrypt_check(input logic [15:0] word, input logic [23:0] addr,
                                 input logic [15:0] exp);
        wb_write(REG_ADDRLO, addr[15:0]);
        wb_write(REG_ADDRHI, {8'h00, addr[23:16]});
        wb_write(REG_CIPHER, word);
        wait_idle();
        wb_read(REG_PLAIN);
        if (rd_data !== exp) begin
            errors++;
            $display("[FAIL] %0t plain got %h expected %h (cipher %h addr %h)", $time, rd_data,
                     exp, word, addr);
        end
    endtask

    task automatic test_reset_state();
        tests++;
        wb_read(REG_STATUS);
        if (rd_data !== 16'h0002) begin             // Beta set, idle, no bytes
            errors++;
            $display("[FAIL] %0t status got %h expected %h", $time, rd_data, 16'h0002);
        end
    endtask

    task automatic test_random_key();
        logic [15:0] w;
        logic [23:0] a;
        tests++;
        for (int i = 0; i < CFG_BYTES; i++) cfg_bytes[i] = 8'(rand32());
        load_key();
        repeat (3) begin
            w = 16'(rand32());
            a = addr_below();
            decrypt_check(w, a, ref_decrypt(w, a));
        end
    endtask

    task automatic test_pass_through();
        logic [15:0] w;
        logic [15:0] top;
        tests++;
        repeat (3) begin
            w   = 16'(rand32());
            top = 16'({16'h0, model_rng()} + rand32() % (32'h10000 - {16'h0, model_rng()}));
            decrypt_check(w, {top, 8'(rand32())}, w);   // Cipher word comes back as is
        end
    endtask

    task automatic test_beta_key();
        logic [11:0] diff;
        logic [15:0] w;
        logic [23:0] a;
        int          need;
        tests++;
        diff = BETA_SUMS[rand32() % 32'(BETA_N)] - m_sum;
        need = int'(diff);
        if (need < 400) need = need + 4096;         // Keeps every byte nonzero
        for (int i = 0; i < CFG_BYTES; i++) begin
            cfg_bytes[i] = 8'(need / (CFG_BYTES - i));
            need         = need - int'(cfg_bytes[i]);
        end
        load_key();
        if (m_beta !== 1'b1) begin
            errors++;
            $display("Beta byte set did not reach a listed checksum at %0t", $time);
        end
        repeat (2) begin
            w = 16'(rand32());
            a = addr_below();
            decrypt_check(w, a, ref_decrypt(w, a));
        end
    endtask

    task automatic test_back_to_back();
        logic [15:0] w1;
        logic [15:0] w2;
        logic [23:0] a;
        tests++;
        w1 = 16'(rand32());
        w2 = 16'(rand32());
        a  = addr_below();
        wb_write(REG_ADDRLO, a[15:0]);
        wb_write(REG_ADDRHI, {8'h00, a[23:16]});
        wb_write(REG_CIPHER, w1);
        wb_write(REG_CIPHER, w2);                   // Second word while first in flight
        wb_read(REG_STATUS);
        if (rd_data[0] !== 1'b1) begin
            errors++;
            $display("[FAIL] %0t busy got %b expected %b", $time, rd_data[0], 1'b1);
        end
        wait_idle();
        wb_read(REG_PLAIN);
        if (rd_data !== ref_decrypt(w2, a)) begin
            errors++;
            $display("[FAIL] %0t plain got %h expected %h", $time, rd_data, ref_decrypt(w2, a));
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 3'd0;
        wb_dat_i = 16'h0000;
        m_raw    = '0;
        m_sum    = '0;
        m_count  = '0;
        m_beta   = 1'b1;                            // Zero checksum reads as beta
        build_perm();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_random_key();
        test_pass_through();
        test_beta_key();
        test_back_to_back();
        finish_run();
    end

endmodule

// ==== flist.f ====
source/cps2_pkg.sv
source/cps2_keyload.sv
source/cps2_wb_regs.sv
source/cps2_decrypt.sv
source/cps2_top.sv
dv/cps2_properties.sv
dv/cps2_tb.sv

// ==== source/cps2_decrypt.sv ====
`timescale 1ns/1ps
// Four stage pipelined Feistel decryptor, one round per stage
// Words outside the address limit pass through with the same latency
module cps2_decrypt (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  logic [cps2_pkg::WORD_W-1:0] in_word,
    input  logic [cps2_pkg::ADDR_W-1:0] in_addr,
    input  logic [cps2_pkg::KEY_W-1:0]  key,
    input  logic [cps2_pkg::RNG_W-1:0]  addr_rng,
    output logic                        out_valid,
    output logic [cps2_pkg::WORD_W-1:0] out_word
);
    import cps2_pkg::*;

    logic       in_en;      // Address below limit
    cps2_word_u in_u;

    // Rotate a byte left, n between 1 and 7
    function automatic logic [7:0] rotl8(input logic [7:0] x, input int n);
        logic [15:0] dbl;
        dbl = {x, x} << n;
        return dbl[15:8];
    endfunction

    // Decision made once, top 16 address bits against the limit
    assign in_en = in_addr[ADDR_W-1 -: RNG_W] < addr_rng;
    assign in_u  = cps2_word_u'(in_word);

    for (genvar r = 0; r < N_ROUNDS; r++) begin : g_round
        logic       v_d;
        logic       en_d;
        logic [7:0] a_d;        // Address low byte, salts the subkey
        logic [7:0] sub;
        cps2_word_u w_d;
        cps2_word_u w_n;

        logic       v_q;
        logic       en_q;
        logic [7:0] a_q;
        cps2_word_u w_q;

        if (r == 0) begin : g_entry
            assign v_d  = in_valid;
            assign en_d = in_en;
            assign a_d  = in_addr[7:0];
            assign w_d  = in_u;
        end else begin : g_chain
            assign v_d  = g_round[r-1].v_q;
            assign en_d = g_round[r-1].en_q;
            assign a_d  = g_round[r-1].a_q;
            assign w_d  = g_round[r-1].w_q;
        end

        assign sub = key[8*r +: 8] ^ a_d;       // Key byte r

        always_comb begin
            w_n = w_d;                          // Pass through by default
            if (en_d) begin
                w_n.half.hi = w_d.half.lo;
                w_n.half.lo = w_d.half.hi ^ rotl8(w_d.half.lo ^ sub, r + 1);
            end
        end

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                v_q <= 1'b0;
            end else begin
                v_q <= v_d;
            end
        end

        // Payload follows valid, no reset needed
        always_ff @(posedge clk) begin
            w_q  <= w_n;
            a_q  <= a_d;
            en_q <= en_d;
        end
    end

    assign out_valid = g_round[N_ROUNDS-1].v_q;        // N_ROUNDS after in_valid
    assign out_word  = g_round[N_ROUNDS-1].w_q.word;

endmodule

// ==== source/cps2_keyload.sv ====
`timescale 1ns/1ps
// Configuration byte loader with checksum based beta detection
// Unscrambles the 160-bit stream into the 64-bit key and the address limit
module cps2_keyload (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [7:0]                 key_byte,
    input  logic                       key_we,
    output logic [cps2_pkg::RNG_W-1:0] addr_rng,
    output logic [cps2_pkg::KEY_W-1:0] key,
    output logic                       beta,
    output logic [4:0]                 byte_count
);
    import cps2_pkg::*;

    logic             we_q;         // Strobe from last cycle
    logic             we_edge;      // One byte per strobe
    logic             sum_new;      // Sum changed on last edge
    logic             sum_hit;      // Sum found in beta list
    logic [SUM_W-1:0] sum;
    logic [CFG_W-1:0] raw;          // Bytes as received, newest on top
    logic [CFG_W-1:0] cfg;          // Unscrambled configuration

    assign we_edge = key_we & ~we_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            we_q       <= 1'b0;
            sum_new    <= 1'b0;
            raw        <= '0;
            sum        <= '0;
            byte_count <= '0;
            beta       <= 1'b1;     // Reads as beta until first byte
        end else begin
            we_q    <= key_we;
            sum_new <= we_edge;
            if (we_edge) begin
                raw        <= {key_byte, raw[CFG_W-1:8]};  // Shift in from top
                sum        <= sum + SUM_W'(key_byte);
                byte_count <= byte_count + 5'd1;          // Wraps at 32
            end
            if (sum_new) begin
                beta <= sum_hit;    // One cycle behind the sum
            end
        end
    end

    // Known development board checksums
    always_comb begin
        case (sum)
            BETA_SUMS[0],  BETA_SUMS[1],  BETA_SUMS[2],  BETA_SUMS[3],
            BETA_SUMS[4],  BETA_SUMS[5],  BETA_SUMS[6],  BETA_SUMS[7],
            BETA_SUMS[8],  BETA_SUMS[9],  BETA_SUMS[10], BETA_SUMS[11],
            BETA_SUMS[12], BETA_SUMS[13], BETA_SUMS[14], BETA_SUMS[15],
            BETA_SUMS[16], BETA_SUMS[17], BETA_SUMS[18], BETA_SUMS[19],
            BETA_SUMS[20], BETA_SUMS[21], BETA_SUMS[22], BETA_SUMS[23],
            BETA_SUMS[24], BETA_SUMS[25]: sum_hit = 1'b1;
            default:                      sum_hit = 1'b0;
        endcase
    end

    // The board scrambles config in 16-bit words. Output word w, counted from
    // the top, takes source word bits 15:10 then 7:0, then bits 9:8 of the
    // source word below it. Words 6..9 come from their pair partner.
    always_comb begin
        int src;
        int base;
        int idx;
        cfg = '0;
        for (int w = 0; w < CFG_W / 16; w++) begin
            src  = (w >= 6) ? (w ^ 1) : w;      // Key words are swapped in pairs
            base = 16 * src;
            for (int j = 0; j < 16; j++) begin
                if (j < 6) begin
                    idx = base + 10 + j;        // Upper six bits first
                end else if (j < 14) begin
                    idx = base + j - 6;         // Low byte
                end else begin
                    idx = (base + CFG_W - 8 + j - 14) % CFG_W;  // Borrowed pair
                end
                cfg[CFG_W - 1 - 16 * w - j] = raw[idx];
            end
        end
    end

    assign addr_rng = cfg[CFG_W-1 -: RNG_W];
    assign key      = cfg[KEY_W-1:0] | {{(KEY_W - 10){1'b0}}, {10{BETA_EN & beta}}};

endmodule

// ==== source/cps2_pkg.sv ====
// Shared widths, register offsets and beta checksum list for the CPS2 decryptor
// Also the opcode word union used by the Feistel stages
package cps2_pkg;

    localparam int CFG_BYTES = 20;              // Configuration bytes per load
    localparam int CFG_W     = CFG_BYTES * 8;   // Raw shift register width
    localparam int KEY_W     = 64;
    localparam int RNG_W     = 16;              // Address limit, top of cfg
    localparam int ADDR_W    = 24;              // Opcode word address
    localparam int WORD_W    = 16;              // Opcode word
    localparam int SUM_W     = 12;              // Byte checksum
    localparam int N_ROUNDS  = 4;               // Rounds and pipeline depth
    localparam int BETA_N    = 26;

    // Beta boards get the low key bits forced high
    localparam logic BETA_EN = 1'b1;

    // Checksums of known development board configurations
    localparam logic [SUM_W-1:0] BETA_SUMS [BETA_N] = '{
        12'h7AC, 12'h7D9, 12'h725, 12'h59F, 12'h6F8, 12'h743,
        12'h70C, 12'h6F5, 12'h6EB, 12'h646, 12'h683,
        12'h51C, 12'h5F9, 12'h604, 12'h4C1,
        12'h741, 12'h6BB,
        12'h647, 12'h628, 12'h4BD, 12'h4B5,
        12'h747, 12'h666, 12'h6C0, 12'h6CF, 12'h6ED
    };

    // Register map, word offsets on wb_adr
    localparam logic [2:0] REG_KEYDATA = 3'd0;  // Config byte, write only strobe
    localparam logic [2:0] REG_STATUS  = 3'd1;  // Busy, beta, byte count
    localparam logic [2:0] REG_ADDRLO  = 3'd2;  // Address bits 15:0
    localparam logic [2:0] REG_ADDRHI  = 3'd3;  // Address bits 23:16
    localparam logic [2:0] REG_CIPHER  = 3'd4;  // Encrypted word, starts decrypt
    localparam logic [2:0] REG_PLAIN   = 3'd5;  // Latest result

    typedef struct packed {
        logic [7:0] hi;                         // Left Feistel half
        logic [7:0] lo;                         // Right Feistel half
    } cps2_half_t;

    // One opcode word, seen whole or as two round halves
    typedef union packed {
        logic [WORD_W-1:0] word;
        cps2_half_t        half;
    } cps2_word_u;

endpackage

// ==== source/cps2_top.sv ====
`timescale 1ns/1ps
// CPS2 decryption front end, bus slave plus key loader plus decryptor
module cps2_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [15:0] wb_dat_i,
    output logic [15:0] wb_dat_o,
    output logic        wb_ack
);
    import cps2_pkg::*;

    logic [7:0]        key_byte;
    logic              key_we;
    logic              beta;
    logic [4:0]        byte_count;
    logic [KEY_W-1:0]  key;
    logic [RNG_W-1:0]  addr_rng;    // Decrypt limit on address bits 23:8
    logic              in_valid;
    logic [WORD_W-1:0] in_word;
    logic [ADDR_W-1:0] in_addr;
    logic              out_valid;
    logic [WORD_W-1:0] out_word;

    cps2_wb_regs i_wb_regs (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack     (wb_ack),
        .key_byte   (key_byte),
        .key_we     (key_we),
        .beta       (beta),
        .byte_count (byte_count),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .in_addr    (in_addr),
        .out_valid  (out_valid),
        .out_word   (out_word)
    );

    cps2_keyload i_keyload (
        .clk        (clk),
        .rst        (rst),
        .key_byte   (key_byte),
        .key_we     (key_we),
        .addr_rng   (addr_rng),
        .key        (key),
        .beta       (beta),
        .byte_count (byte_count)
    );

    cps2_decrypt i_decrypt (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .in_addr    (in_addr),
        .key        (key),
        .addr_rng   (addr_rng),
        .out_valid  (out_valid),
        .out_word   (out_word)
    );

endmodule

// ==== source/cps2_wb_regs.sv ====
`timescale 1ns/1ps
// Wishbone classic slave with the decryptor register map
// Drives key byte strobes and decrypt requests, captures results
module cps2_wb_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [2:0]                  wb_adr,
    input  logic [15:0]                 wb_dat_i,
    output logic [15:0]                 wb_dat_o,
    output logic                        wb_ack,
    output logic [7:0]                  key_byte,
    output logic                        key_we,
    input  logic                        beta,
    input  logic [4:0]                  byte_count,
    output logic                        in_valid,
    output logic [cps2_pkg::WORD_W-1:0] in_word,
    output logic [cps2_pkg::ADDR_W-1:0] in_addr,
    input  logic                        out_valid,
    input  logic [cps2_pkg::WORD_W-1:0] out_word
);
    import cps2_pkg::*;

    logic              acc;         // Transfer taken this cycle
    logic              wr;
    logic [15:0]       addr_lo;
    logic [7:0]        addr_hi;
    logic [WORD_W-1:0] plain;       // Latest decryptor result
    logic [1:0]        pend;        // Words in flight
    logic              busy;
    logic [15:0]       rd_mux;

    // No wait states, second cycle of a transfer is the ack
    assign acc     = wb_cyc & wb_stb & ~wb_ack;
    assign wr      = acc & wb_we;
    assign busy    = |pend;
    assign in_addr = {addr_hi, addr_lo};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            key_we   <= 1'b0;
            in_valid <= 1'b0;
            addr_lo  <= '0;
            addr_hi  <= '0;
            plain    <= '0;
            pend     <= '0;
        end else begin
            wb_ack   <= acc;                            // Single cycle ack
            key_we   <= wr && (wb_adr == REG_KEYDATA);
            in_valid <= wr && (wb_adr == REG_CIPHER);
            if (wr && (wb_adr == REG_ADDRLO)) begin
                addr_lo <= wb_dat_i;
            end
            if (wr && (wb_adr == REG_ADDRHI)) begin
                addr_hi <= wb_dat_i[7:0];
            end
            if (out_valid) begin
                plain <= out_word;                      // Newest result wins
            end
            case ({in_valid, out_valid})
                2'b10:   pend <= pend + 2'd1;
                2'b01:   pend <= pend - 2'd1;
                default: pend <= pend;                  // Both or neither
            endcase
        end
    end

    // Data path registers
    always_ff @(posedge clk) begin
        if (wr && (wb_adr == REG_KEYDATA)) begin
            key_byte <= wb_dat_i[7:0];
        end
        if (wr && (wb_adr == REG_CIPHER)) begin
            in_word <= wb_dat_i;
        end
        if (acc) begin
            wb_dat_o <= rd_mux;                         // Valid with ack
        end
    end

    always_comb begin
        case (wb_adr)
            REG_KEYDATA: rd_mux = {8'h00, key_byte};
            REG_STATUS:  rd_mux = {8'h00, byte_count, 1'b0, beta, busy};
            REG_ADDRLO:  rd_mux = addr_lo;
            REG_ADDRHI:  rd_mux = {8'h00, addr_hi};
            REG_CIPHER:  rd_mux = in_word;
            REG_PLAIN:   rd_mux = plain;
            default:     rd_mux = 16'h0000;             // Unmapped
        endcase
    end

endmodule
